//--- src/sma_pkg.sv
`default_nettype none

package sma_pkg;

	// filter bank geometry
	localparam int NUM_CHANNELS = 4;
	localparam int CH_W = 2;

	// signed sample and average width
	localparam int DATA_W = 16;

	// largest window is 2^6 samples, so the memory holds 64 entries
	localparam int MAX_LOG2_WIN = 6;
	localparam int MEM_DEPTH = 1 << MAX_LOG2_WIN;

	// window code, values above MAX_LOG2_WIN are rejected
	localparam int WIN_CODE_W = 3;

	// running sum grows by one bit per doubling of the window
	localparam int SUM_W = DATA_W + MAX_LOG2_WIN;

	// tagged input sample
	typedef struct packed {
		logic [CH_W-1:0] channel;
		logic signed [DATA_W-1:0] data;
	} sample_t;

	// tagged output average
	typedef struct packed {
		logic [CH_W-1:0] channel;
		logic signed [DATA_W-1:0] average;
	} result_t;

endpackage

`default_nettype wire

//--- src/window_config.sv
`default_nettype none
`timescale 1ns/1ps

module window_config (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_cfg_we,
	input wire [sma_pkg::CH_W-1:0] i_cfg_channel,
	input wire [sma_pkg::WIN_CODE_W-1:0] i_cfg_log2_win,
	output logic [sma_pkg::NUM_CHANNELS-1:0][sma_pkg::WIN_CODE_W-1:0] o_log2_win,
	output logic [sma_pkg::NUM_CHANNELS-1:0] o_clear
);
	import sma_pkg::*;

	logic code_ok;
	logic code_differs;
	logic accept;

	// code 7 would ask for a window larger than the memory
	assign code_ok = (i_cfg_log2_win <= WIN_CODE_W'(MAX_LOG2_WIN));

	// rewriting the same code must leave the history alone
	assign code_differs = (i_cfg_log2_win != o_log2_win[i_cfg_channel]);

	assign accept = i_cfg_we && code_ok && code_differs;

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			// code 0 is a window of one sample
			o_log2_win <= '0;
			o_clear <= '0;
		end else begin
			for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
				if (accept && (i_cfg_channel == CH_W'(ch))) begin
					o_log2_win[ch] <= i_cfg_log2_win;
					o_clear[ch] <= 1'b1;
				end else begin
					// clear is a single cycle pulse
					o_clear[ch] <= 1'b0;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- src/sample_router.sv
`default_nettype none
`timescale 1ns/1ps

module sample_router (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_sample_strobe,
	input wire sma_pkg::sample_t i_sample,
	output logic [sma_pkg::NUM_CHANNELS-1:0] o_update,
	output logic signed [sma_pkg::DATA_W-1:0] o_data
);
	import sma_pkg::*;

	logic [NUM_CHANNELS-1:0] channel_onehot;

	// one-hot decode of the channel tag
	always_comb begin
		channel_onehot = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			if (i_sample.channel == CH_W'(ch)) begin
				channel_onehot[ch] = 1'b1;
			end
		end
	end

	// update strobes drop back to zero when no sample arrives
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_update <= '0;
		end else if (i_sample_strobe) begin
			o_update <= channel_onehot;
		end else begin
			o_update <= '0;
		end
	end

	// sample value is shared by all channels, only the strobe selects
	always_ff @(posedge i_clk) begin
		if (i_sample_strobe) begin
			o_data <= i_sample.data;
		end
	end

endmodule

`default_nettype wire

//--- src/moving_average.sv
`default_nettype none
`timescale 1ns/1ps

module moving_average (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_update,
	input wire i_clear,
	input wire [sma_pkg::WIN_CODE_W-1:0] i_log2_win,
	input wire signed [sma_pkg::DATA_W-1:0] i_data,
	output logic o_valid,
	output logic signed [sma_pkg::DATA_W-1:0] o_average
);
	import sma_pkg::*;

	// circular sample history
	logic signed [DATA_W-1:0] mem [MEM_DEPTH];

	logic [MAX_LOG2_WIN-1:0] wr_idx;
	logic signed [SUM_W-1:0] sum;
	// number of entries written since the last clear, saturates at the window size
	logic [MAX_LOG2_WIN:0] fill;

	logic [MAX_LOG2_WIN:0] win_size;
	logic [MAX_LOG2_WIN-1:0] win_mask;

	logic [MAX_LOG2_WIN-1:0] base_idx;
	logic signed [SUM_W-1:0] base_sum;
	logic [MAX_LOG2_WIN:0] base_fill;
	logic window_full;

	logic signed [DATA_W-1:0] old_sample;
	logic signed [SUM_W-1:0] new_sum;
	logic signed [SUM_W-1:0] shifted_sum;
	logic [MAX_LOG2_WIN-1:0] next_idx;
	logic [MAX_LOG2_WIN:0] next_fill;

	assign win_size = (MAX_LOG2_WIN + 1)'(1) << i_log2_win;
	assign win_mask = MAX_LOG2_WIN'(win_size - 1'b1);

	always_comb begin
		// a clear restarts the window, a sample in the same cycle becomes its first entry
		if (i_clear) begin
			base_idx = '0;
			base_sum = '0;
			base_fill = '0;
		end else begin
			base_idx = wr_idx;
			base_sum = sum;
			base_fill = fill;
		end

		window_full = (base_fill == win_size);

		// entries not written since the clear count as zero
		if (window_full) begin
			old_sample = mem[base_idx];
		end else begin
			old_sample = '0;
		end

		new_sum = base_sum + SUM_W'(i_data) - SUM_W'(old_sample);

		// divide by the full window, so early results are zero-padded
		shifted_sum = new_sum >>> i_log2_win;

		// index wraps at the window size, not at the memory depth
		next_idx = (base_idx + 1'b1) & win_mask;

		if (window_full) begin
			next_fill = base_fill;
		end else begin
			next_fill = base_fill + 1'b1;
		end
	end

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			wr_idx <= '0;
			sum <= '0;
			fill <= '0;
			o_valid <= 1'b0;
		end else begin
			o_valid <= i_update;
			if (i_update) begin
				wr_idx <= next_idx;
				sum <= new_sum;
				fill <= next_fill;
			end else if (i_clear) begin
				wr_idx <= '0;
				sum <= '0;
				fill <= '0;
			end
		end
	end

	// history and average carry no reset
	always_ff @(posedge i_clk) begin
		if (i_update) begin
			mem[base_idx] <= i_data;
			// average never exceeds the largest sample magnitude, upper bits are sign
			o_average <= shifted_sum[DATA_W-1:0];
		end
	end

endmodule

`default_nettype wire

//--- src/result_collector.sv
`default_nettype none
`timescale 1ns/1ps

module result_collector (
	input wire i_clk,
	input wire i_rst_n,
	input wire [sma_pkg::NUM_CHANNELS-1:0] i_valid,
	input wire [sma_pkg::NUM_CHANNELS-1:0][sma_pkg::DATA_W-1:0] i_average,
	output logic o_result_valid,
	output sma_pkg::result_t o_result
);
	import sma_pkg::*;

	logic any_valid;
	logic [CH_W-1:0] sel_channel;
	logic signed [DATA_W-1:0] sel_average;

	// router strobes one channel at a time, so at most one valid bit is set
	assign any_valid = |i_valid;

	// encode the active valid bit into a channel number
	always_comb begin
		sel_channel = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			if (i_valid[ch]) begin
				sel_channel = CH_W'(ch);
			end
		end
	end

	assign sel_average = i_average[sel_channel];

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_result_valid <= 1'b0;
		end else begin
			o_result_valid <= any_valid;
		end
	end

	// tagged payload, only loaded when a channel produced a result
	always_ff @(posedge i_clk) begin
		if (any_valid) begin
			o_result.channel <= sel_channel;
			o_result.average <= sel_average;
		end
	end

endmodule

`default_nettype wire

//--- src/sma_bank_top.sv
`default_nettype none
`timescale 1ns/1ps

module sma_bank_top (
	input wire i_clk,
	input wire i_rst_n,
	input wire i_sample_strobe,
	input wire sma_pkg::sample_t i_sample,
	input wire i_cfg_we,
	input wire [sma_pkg::CH_W-1:0] i_cfg_channel,
	input wire [sma_pkg::WIN_CODE_W-1:0] i_cfg_log2_win,
	output logic o_result_valid,
	output sma_pkg::result_t o_result
);
	import sma_pkg::*;

	logic [NUM_CHANNELS-1:0][WIN_CODE_W-1:0] log2_win;
	logic [NUM_CHANNELS-1:0] clear;
	logic [NUM_CHANNELS-1:0] update;
	logic signed [DATA_W-1:0] routed_data;
	logic [NUM_CHANNELS-1:0] ch_valid;
	logic [NUM_CHANNELS-1:0][DATA_W-1:0] ch_average;

	window_config u_window_config (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_cfg_we (i_cfg_we),
		.i_cfg_channel (i_cfg_channel),
		.i_cfg_log2_win (i_cfg_log2_win),
		.o_log2_win (log2_win),
		.o_clear (clear)
	);

	sample_router u_sample_router (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_sample_strobe (i_sample_strobe),
		.i_sample (i_sample),
		.o_update (update),
		.o_data (routed_data)
	);

	// one filter per channel, all fed from the shared routed sample
	for (genvar g = 0; g < NUM_CHANNELS; g++) begin : g_channel
		moving_average u_moving_average (
			.i_clk (i_clk),
			.i_rst_n (i_rst_n),
			.i_update (update[g]),
			.i_clear (clear[g]),
			.i_log2_win (log2_win[g]),
			.i_data (routed_data),
			.o_valid (ch_valid[g]),
			.o_average (ch_average[g])
		);
	end

	result_collector u_result_collector (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_valid (ch_valid),
		.i_average (ch_average),
		.o_result_valid (o_result_valid),
		.o_result (o_result)
	);

endmodule

`default_nettype wire

//--- testbench/tb_sma_bank.sv
`default_nettype none
`timescale 1ns/1ps

module tb_sma_bank;
	import sma_pkg::*;

	localparam int RESET_CYCLES = 10;
	localparam int N_IDLE = 20;
	localparam int N_RAMP = 40;
	localparam int N_RANDOM = 300;
	localparam int N_SEG = 12;
	localparam int N_BAD = 8;
	localparam int N_FULL = 200;
	localparam int DRAIN_CYCLES = 8;
	localparam int STIM_CYCLES = RESET_CYCLES + N_IDLE + NUM_CHANNELS + 1 + N_RAMP
		+ NUM_CHANNELS + N_RANDOM + 3 + 3 * N_SEG + 2 + 2 * N_BAD + 1 + N_FULL
		+ 6 * DRAIN_CYCLES;
	localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES + 100;

	logic i_clk;
	logic i_rst_n;
	logic i_sample_strobe;
	sample_t i_sample;
	logic i_cfg_we;
	logic [CH_W-1:0] i_cfg_channel;
	logic [WIN_CODE_W-1:0] i_cfg_log2_win;
	logic o_result_valid;
	result_t o_result;

	// reference model state
	int hist [NUM_CHANNELS][MEM_DEPTH];
	int fill [NUM_CHANNELS];
	int win_code [NUM_CHANNELS];
	result_t exp_q [$];

	integer seed;
	int err_count;
	int pass_count;
	int fail_count;
	int cycle_count;
	int test_errs;
	int rnd;
	int rnd2;

	sma_bank_top i_dut (
		.i_clk (i_clk),
		.i_rst_n (i_rst_n),
		.i_sample_strobe (i_sample_strobe),
		.i_sample (i_sample),
		.i_cfg_we (i_cfg_we),
		.i_cfg_channel (i_cfg_channel),
		.i_cfg_log2_win (i_cfg_log2_win),
		.o_result_valid (o_result_valid),
		.o_result (o_result)
	);

	always #10 i_clk = ~i_clk;

	// three cycle latency, and no result without a strobe
	a_result_timing: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_result_valid == $past(i_sample_strobe, 3))
	else begin
		$display("ERR %0t ns: o_result_valid does not match a strobe 3 cycles earlier", $time);
		err_count++;
	end

	// outputs settle well before the falling edge
	always @(negedge i_clk) begin
		result_t head;
		if (i_rst_n && o_result_valid) begin
			if (exp_q.size() == 0) begin
				$display("a result arrived at %0t ns while no result was expected", $time);
				err_count++;
			end else begin
				head = exp_q.pop_front();
				a_result_value: assert (o_result == head)
				else begin
					$display("ERR %0t ns: got ch %0d avg %0d, expected ch %0d avg %0d",
						$time, o_result.channel, o_result.average, head.channel, head.average);
					err_count++;
				end
			end
		end
	end

	always @(posedge i_clk) begin
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$finish;
		end
	end

	// an accepted write with a new code empties the history
	function automatic void model_config(input int ch, input int code);
		if (code <= MAX_LOG2_WIN && code != win_code[ch]) begin
			win_code[ch] = code;
			fill[ch] = 0;
		end
	endfunction

	function automatic void model_sample(input int ch, input logic signed [DATA_W-1:0] data);
		for (int i = MEM_DEPTH - 1; i > 0; i--) begin
			hist[ch][i] = hist[ch][i-1];
		end
		hist[ch][0] = data;
		if (fill[ch] < MEM_DEPTH) begin
			fill[ch]++;
		end
	endfunction

	// missing entries count as zero, divide by the full window
	function automatic logic signed [DATA_W-1:0] expected_average(input int ch);
		int total;
		int count;
		total = 0;
		count = (fill[ch] < (1 << win_code[ch])) ? fill[ch] : (1 << win_code[ch]);
		for (int i = 0; i < count; i++) begin
			total += hist[ch][i];
		end
		return DATA_W'(total >>> win_code[ch]);
	endfunction

	task automatic drive_cycle(input logic do_sample, input int ch,
		input logic signed [DATA_W-1:0] data, input logic do_cfg, input int cfg_ch,
		input int code);
		result_t exp;
		@(posedge i_clk);
		i_sample_strobe <= do_sample;
		i_sample.channel <= CH_W'(ch);
		i_sample.data <= data;
		i_cfg_we <= do_cfg;
		i_cfg_channel <= CH_W'(cfg_ch);
		i_cfg_log2_win <= WIN_CODE_W'(code);
		// a write in the same cycle takes effect before the sample
		if (do_cfg) begin
			model_config(cfg_ch, code);
		end
		if (do_sample) begin
			model_sample(ch, data);
			exp.channel = CH_W'(ch);
			exp.average = expected_average(ch);
			exp_q.push_back(exp);
		end
	endtask

	task automatic send_sample(input int ch, input logic signed [DATA_W-1:0] data);
		drive_cycle(1'b1, ch, data, 1'b0, 0, 0);
	endtask

	task automatic write_window(input int ch, input int code);
		drive_cycle(1'b0, 0, '0, 1'b1, ch, code);
	endtask

	task automatic idle_cycle();
		drive_cycle(1'b0, 0, '0, 1'b0, 0, 0);
	endtask

	task automatic drain_results();
		idle_cycle();
		while (exp_q.size() != 0) begin
			@(posedge i_clk);
		end
		repeat (DRAIN_CYCLES - 4) @(posedge i_clk);
	endtask

	task automatic end_test(input string name);
		drain_results();
		if (err_count == test_errs) begin
			pass_count++;
			$display("test %s: PASS", name);
		end else begin
			fail_count++;
			$display("test %s: FAIL with %0d errors", name, err_count - test_errs);
		end
		test_errs = err_count;
	endtask

	initial begin
		seed = 55081;
		i_clk = 1'b0;
		i_rst_n = 1'b0;
		i_sample_strobe = 1'b0;
		i_sample = '0;
		i_cfg_we = 1'b0;
		i_cfg_channel = '0;
		i_cfg_log2_win = '0;
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			fill[ch] = 0;
			win_code[ch] = 0;
		end
		repeat (RESET_CYCLES) @(posedge i_clk);
		i_rst_n <= 1'b1;

		// window of one after reset
		repeat (N_IDLE) idle_cycle();
		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			rnd = $random(seed);
			send_sample(ch, rnd[15:0]);
		end
		end_test("reset_window_one");

		write_window(0, 3);
		for (int i = 0; i < N_RAMP; i++) begin
			send_sample(0, DATA_W'(i * 37 - 300));
		end
		end_test("ramp_window_8");

		for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
			write_window(ch, ch + 1);
		end
		// occasional writes, some in the same cycle as a sample
		for (int i = 0; i < N_RANDOM; i++) begin
			rnd = $random(seed);
			rnd2 = $random(seed);
			drive_cycle(1'b1, int'(rnd[17:16]), rnd[15:0], rnd2[3:0] == 4'd0,
				int'(rnd2[9:8]), int'(rnd2[6:4]));
		end
		end_test("random_mixed_channels");

		write_window(1, 2);
		for (int i = 0; i < N_SEG; i++) begin
			send_sample(1, DATA_W'(i * 250 - 1000));
		end
		write_window(1, 4);
		for (int i = 0; i < N_SEG; i++) begin
			send_sample(1, DATA_W'(700 - i * 90));
		end
		// same code again keeps the history
		write_window(1, 4);
		for (int i = 0; i < N_SEG; i++) begin
			send_sample(1, DATA_W'(i * 1111));
		end
		end_test("window_change_clears");

		write_window(2, 2);
		for (int i = 0; i < N_BAD; i++) begin
			send_sample(2, DATA_W'(i * 500 + 3));
		end
		write_window(2, 7);
		for (int i = 0; i < N_BAD; i++) begin
			send_sample(2, DATA_W'(-i * 321));
		end
		end_test("invalid_code_ignored");

		write_window(3, 6);
		for (int i = 0; i < N_FULL; i++) begin
			rnd = $random(seed);
			case (rnd[19:18])
				2'd0: send_sample(3, 16'sh8000);
				2'd1: send_sample(3, 16'sh7fff);
				default: send_sample(3, rnd[15:0]);
			endcase
		end
		end_test("full_scale_window_64");

		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
		if (fail_count == 0 && err_count == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
src/sma_pkg.sv
src/window_config.sv
src/sample_router.sv
src/moving_average.sv
src/result_collector.sv
src/sma_bank_top.sv
testbench/tb_sma_bank.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the moving-average filter bank testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f list.f \
	--top-module tb_sma_bank \
	-Mdir obj_dir

./obj_dir/Vtb_sma_bank | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run_sim: testbench reported a failure"
	exit 1
fi

if ! grep -q "Simulation passed" sim.log; then
	echo "run_sim: testbench ended without a verdict"
	exit 1
fi
